// File: tests/periph_stimulus.txt
# columns (hex): op addr wdata be exp_rdata exp_err; for writes exp_rdata 1 means the grant stalls
# op: 0 read, 1 write, 2 read and 3 write without idle gap, 4 pulse event line addr, 5 wait event_o
0 00004000 00000000 f 00000000 0
1 00004000 000000f0 1 00000000 0
0 00004000 00000000 f 000000f0 0
1 00004000 0000ff0f e 00000000 0
0 00004000 00000000 f 000000f0 0
4 00000003 00000000 0 00000000 0
0 00004004 00000000 f 00000008 0
0 0000400c 00000000 f 00000000 0
1 00004000 00000009 1 00000000 0
1 00004008 00000008 1 00000000 0
0 00004004 00000000 f 00000000 0
4 00000003 00000000 0 00000001 0
0 0000400c 00000000 f 00000008 0
1 00004008 00000008 1 00000000 0
0 00004004 00000000 f 00000000 0
1 00004408 00000010 f 00000000 0
0 00004408 00000000 f 00000010 0
1 0000440c 00000001 1 00000000 0
2 0000440c 00000000 f 00000001 0
5 00000000 00000000 0 00000000 0
0 00004004 00000000 f 00000001 0
0 0000400c 00000000 f 00000001 0
1 00004008 00000001 1 00000000 0
1 00004408 00000008 f 00000000 0
1 0000440c 00000001 1 00000000 0
3 0000440c 00000001 1 00000001 0
2 0000440c 00000000 f 00000001 0
1 00004008 00000001 1 00000000 0
5 00000000 00000000 0 00000000 0
1 00004008 00000001 1 00000000 0
0 00004004 00000000 f 00000000 0
0 00008000 00000000 f 00000000 1
1 00004800 12345678 f 00000000 1
0 00000000 00000000 f 00000000 1
2 00004c0c 00000000 f 00000000 1
1 00004400 deadbeef f 00000000 0
2 00004000 00000000 f 00000009 0
3 00004404 12345678 f 00000000 0
2 00004004 00000000 f 00000000 0
2 00004400 00000000 f deadbeef 0
2 0000400c 00000000 f 00000000 0
2 00004404 00000000 f 12345678 0
3 00004400 aabbccdd 5 00000000 0
2 00004400 00000000 f debbbedd 0

// File: project.f
+incdir+source
source/periph_pkg.sv
source/periph_demux.sv
source/event_unit_regs.sv
source/dma_ctrl_regs.sv
source/periph_cluster_top.sv
tests/tb_periph_cluster.sv

// File: Bender.yml
package:
  name: periph_cluster

export_include_dirs:
  - source

sources:
  - source/periph_pkg.sv
  - source/periph_demux.sv
  - source/event_unit_regs.sv
  - source/dma_ctrl_regs.sv
  - source/periph_cluster_top.sv
  - target: test
    files:
      - tests/tb_periph_cluster.sv

// File: tests/tb_periph_cluster.sv
`timescale 1ns/10ps
`include "periph_macros.svh"

module tb_periph_cluster;

  localparam int CLK_PERIOD = 20;
  localparam int TIMEOUT    = 200;  // cycles per wait loop

  logic                   clk;
  logic                   rst_ni;
  logic                   data_req;
  logic [`ADDR_WIDTH-1:0] data_add;
  logic                   data_wen;
  logic [`DATA_WIDTH-1:0] data_wdata;
  logic [`BE_WIDTH-1:0]   data_be;
  logic                   data_gnt;
  logic                   data_r_valid;
  logic [`DATA_WIDTH-1:0] data_r_rdata;
  logic                   data_r_opc;
  logic [`NUM_EVENTS-2:0] evt;
  logic                   eu_event;
  int                     errors;
  int                     timeouts;

  periph_cluster_top u_periph_cluster_top (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .data_req_i     (data_req),
    .data_add_i     (data_add),
    .data_wen_i     (data_wen),
    .data_wdata_i   (data_wdata),
    .data_be_i      (data_be),
    .data_gnt_o     (data_gnt),
    .data_r_valid_o (data_r_valid),
    .data_r_rdata_o (data_r_rdata),
    .data_r_opc_o   (data_r_opc),
    .evt_i          (evt),
    .event_o        (eu_event)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // one core access from falling edge to falling edge
  task automatic do_access(input int line_no, input logic is_write, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] be,
                           input logic [31:0] exp_rdata, input logic exp_err);
    int    stall;
    int    delay;
    string name;
    name       = $sformatf("line %0d", line_no);
    data_req   = 1'b1;
    data_add   = addr;
    data_wen   = !is_write;  // high means read
    data_wdata = wdata;
    data_be    = be;
    stall      = 0;
    #(CLK_PERIOD/4);  // gnt settled before the rising edge
    while (!data_gnt && stall < TIMEOUT)
    begin
      @(negedge clk);
      stall++;
      #(CLK_PERIOD/4);
    end
    if (!data_gnt)
    begin
      $display("Timeout on line %0d: the request was never granted", line_no);
      timeouts++;
      return;
    end
    @(negedge clk);
    data_req = 1'b0;
    delay    = 0;
    while (!data_r_valid && delay < TIMEOUT)
    begin
      @(negedge clk);
      delay++;
    end
    if (!data_r_valid)
    begin
      $display("Timeout on line %0d: no response after the grant", line_no);
      timeouts++;
      return;
    end
    check({name, " response delay"}, 0, delay);
    check({name, " grant stall"}, is_write ? exp_rdata[0] : 1'b0, stall != 0);
    if (!is_write)
    begin
      check({name, " rdata"}, exp_rdata, data_r_rdata);
    end
    check({name, " error bit"}, exp_err, data_r_opc);
  endtask

  task automatic pulse_event(input int line_no, input int line_idx, input logic exp_event);
    if (line_idx < 1 || line_idx > `NUM_EVENTS-1)
    begin
      $display("Line %0d asks for event line %0d, which the core port cannot drive",
               line_no, line_idx);
      errors++;
      return;
    end
    evt = '0;
    evt[line_idx-1] = 1'b1;  // evt bit 0 is event line 1
    @(negedge clk);
    evt = '0;
    check($sformatf("line %0d event_o", line_no), exp_event, eu_event);
  endtask

  task automatic wait_event(input int line_no);
    int cycles;
    cycles = 0;
    while (!eu_event && cycles < TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!eu_event)
    begin
      $display("Timeout on line %0d: the event output never rose", line_no);
      timeouts++;
    end
  endtask

  initial
  begin
    int          fd;
    int          c;
    int          n;
    int          line_no;
    int          gap;
    int          seed;
    logic [3:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic [31:0] exp_rdata;
    logic        exp_err;
    errors     = 0;
    timeouts   = 0;
    seed       = 32'h221c;
    void'($urandom(seed));
    rst_ni     = 1'b0;
    data_req   = 1'b0;
    data_add   = '0;
    data_wen   = 1'b1;
    data_wdata = '0;
    data_be    = '0;
    evt        = '0;
    repeat (10) @(negedge clk);
    rst_ni = 1'b1;
    check("reset r_valid", 0, data_r_valid);
    check("reset event_o", 0, eu_event);
    fd = $fopen("tests/periph_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the stimulus file tests/periph_stimulus.txt");
      errors++;
    end
    line_no = 1;
    while (fd != 0 && !$feof(fd) && timeouts == 0)
    begin
      c = $fgetc(fd);
      if (c == "\n")
      begin
        line_no++;
      end
      else if (c == "#")
      begin
        while (c != "\n" && c != -1)
        begin
          c = $fgetc(fd);
        end
        line_no++;
      end
      else if (c >= "0" && c <= "9")
      begin
        op = 4'(c - "0");
        n  = $fscanf(fd, " %h %h %h %h %h", addr, wdata, be, exp_rdata, exp_err);
        if (n != 5)
        begin
          $display("Line %0d of the stimulus file has missing fields", line_no);
          errors++;
        end
        else
        begin
          case (op)
            4'h0, 4'h1:
            begin
              gap = $urandom % 3;  // idle cycles before the access
              repeat (gap) @(negedge clk);
              do_access(line_no, op[0], addr, wdata, be, exp_rdata, exp_err);
            end
            4'h2, 4'h3: do_access(line_no, op[0], addr, wdata, be, exp_rdata, exp_err);
            4'h4:       pulse_event(line_no, int'(addr), exp_rdata[0]);
            4'h5:       wait_event(line_no);
            default:
            begin
              $display("Line %0d holds an unknown operation %h", line_no, op);
              errors++;
            end
          endcase
        end
      end
    end
    if (fd != 0)
    begin
      $fclose(fd);
    end
    $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: source/periph_cluster_top.sv
`timescale 1ns/10ps
`include "periph_macros.svh"

module periph_cluster_top
(
  input  logic                   clk,
  input  logic                   rst_ni,
  input  logic                   data_req_i,
  input  logic [`ADDR_WIDTH-1:0] data_add_i,
  input  logic                   data_wen_i,
  input  logic [`DATA_WIDTH-1:0] data_wdata_i,
  input  logic [`BE_WIDTH-1:0]   data_be_i,
  output logic                   data_gnt_o,
  output logic                   data_r_valid_o,
  output logic [`DATA_WIDTH-1:0] data_r_rdata_o,
  output logic                   data_r_opc_o,
  input  logic [`NUM_EVENTS-2:0] evt_i,
  output logic                   event_o
);

  logic                   eu_req, eu_gnt, eu_r_valid;
  logic [`DATA_WIDTH-1:0] eu_r_rdata;
  logic                   dma_req, dma_gnt, dma_r_valid;
  logic [`DATA_WIDTH-1:0] dma_r_rdata;
  logic [`ADDR_WIDTH-1:0] add;
  logic                   wen;
  logic [`DATA_WIDTH-1:0] wdata;
  logic [`BE_WIDTH-1:0]   be;
  logic                   dma_done;
  logic [`NUM_EVENTS-1:0] events;

  assign events = {evt_i, dma_done};  // dma done is event 0

  periph_demux u_periph_demux (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .data_req_i     (data_req_i),
    .data_add_i     (data_add_i),
    .data_wen_i     (data_wen_i),
    .data_wdata_i   (data_wdata_i),
    .data_be_i      (data_be_i),
    .data_gnt_o     (data_gnt_o),
    .data_r_valid_o (data_r_valid_o),
    .data_r_rdata_o (data_r_rdata_o),
    .data_r_opc_o   (data_r_opc_o),
    .eu_req_o       (eu_req),
    .eu_gnt_i       (eu_gnt),
    .eu_r_valid_i   (eu_r_valid),
    .eu_r_rdata_i   (eu_r_rdata),
    .dma_req_o      (dma_req),
    .dma_gnt_i      (dma_gnt),
    .dma_r_valid_i  (dma_r_valid),
    .dma_r_rdata_i  (dma_r_rdata),
    .add_o          (add),
    .wen_o          (wen),
    .wdata_o        (wdata),
    .be_o           (be)
  );

  event_unit_regs u_event_unit_regs (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .req_i     (eu_req),
    .add_i     (add),
    .wen_i     (wen),
    .wdata_i   (wdata),
    .be_i      (be),
    .gnt_o     (eu_gnt),
    .r_valid_o (eu_r_valid),
    .r_rdata_o (eu_r_rdata),
    .evt_i     (events),
    .event_o   (event_o)
  );

  dma_ctrl_regs u_dma_ctrl_regs (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .req_i     (dma_req),
    .add_i     (add),
    .wen_i     (wen),
    .wdata_i   (wdata),
    .be_i      (be),
    .gnt_o     (dma_gnt),
    .r_valid_o (dma_r_valid),
    .r_rdata_o (dma_r_rdata),
    .done_o    (dma_done)
  );

endmodule

// File: source/dma_ctrl_regs.sv
`timescale 1ns/10ps
`include "periph_macros.svh"

module dma_ctrl_regs
(
  input  logic                   clk,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic [`ADDR_WIDTH-1:0] add_i,
  input  logic                   wen_i,
  input  logic [`DATA_WIDTH-1:0] wdata_i,
  input  logic [`BE_WIDTH-1:0]   be_i,
  output logic                   gnt_o,
  output logic                   r_valid_o,
  output logic [`DATA_WIDTH-1:0] r_rdata_o,
  output logic                   done_o
);

  periph_pkg::dma_reg_e      reg_sel;
  logic [`DATA_WIDTH-1:0]    src_q, dst_q;
  logic [`DMA_LEN_WIDTH-1:0] len_q, cnt_q;
  logic                      busy_q;
  logic                      wr, start;

  function automatic logic [`DATA_WIDTH-1:0] be_merge(logic [`DATA_WIDTH-1:0] old_val,
                                                      logic [`DATA_WIDTH-1:0] new_val,
                                                      logic [`BE_WIDTH-1:0] be);
    logic [`DATA_WIDTH-1:0] res;
    res = old_val;
    for (int b = 0; b < `BE_WIDTH; b++)
    begin
      if (be[b])
      begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign reg_sel = periph_pkg::dma_reg_e'(add_i[3:2]);
  assign wr      = req_i && !wen_i;
  assign start   = wr && (reg_sel == periph_pkg::DMA_CMD) && be_i[0] && wdata_i[0];
  assign gnt_o   = req_i && !(start && busy_q);  // hold off restart while busy

  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      src_q     <= '0;
      dst_q     <= '0;
      len_q     <= '0;
      cnt_q     <= '0;
      busy_q    <= 1'b0;
      done_o    <= 1'b0;
      r_valid_o <= 1'b0;
      r_rdata_o <= '0;
    end
    else
    begin
      done_o    <= 1'b0;
      r_valid_o <= gnt_o;
      if (wr && gnt_o)
      begin
        case (reg_sel)
          periph_pkg::DMA_SRC: src_q <= be_merge(src_q, wdata_i, be_i);
          periph_pkg::DMA_DST: dst_q <= be_merge(dst_q, wdata_i, be_i);
          periph_pkg::DMA_LEN:
            len_q <= `DMA_LEN_WIDTH'(be_merge(`DATA_WIDTH'(len_q), wdata_i, be_i));
          default: ;
        endcase
      end
      if (start && gnt_o)
      begin
        busy_q <= 1'b1;
        cnt_q  <= len_q;
      end
      else if (busy_q)
      begin
        if (cnt_q == '0)
        begin
          busy_q <= 1'b0;
          done_o <= 1'b1;
        end
        else
        begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
      if (req_i && wen_i)
      begin
        case (reg_sel)
          periph_pkg::DMA_SRC: r_rdata_o <= src_q;
          periph_pkg::DMA_DST: r_rdata_o <= dst_q;
          periph_pkg::DMA_LEN: r_rdata_o <= `DATA_WIDTH'(len_q);
          default:             r_rdata_o <= `DATA_WIDTH'(busy_q);
        endcase
      end
    end
  end

  // done only right after busy ends
  a_done_after_busy: assert property (@(posedge clk) disable iff (!rst_ni)
    done_o |-> !busy_q && $past(busy_q));

endmodule

// File: source/event_unit_regs.sv
`timescale 1ns/10ps
`include "periph_macros.svh"

module event_unit_regs
(
  input  logic                   clk,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic [`ADDR_WIDTH-1:0] add_i,
  input  logic                   wen_i,
  input  logic [`DATA_WIDTH-1:0] wdata_i,
  input  logic [`BE_WIDTH-1:0]   be_i,
  output logic                   gnt_o,
  output logic                   r_valid_o,
  output logic [`DATA_WIDTH-1:0] r_rdata_o,
  input  logic [`NUM_EVENTS-1:0] evt_i,
  output logic                   event_o
);

  periph_pkg::eu_reg_e     reg_sel;
  logic [`NUM_EVENTS-1:0] be_bits;
  logic [`NUM_EVENTS-1:0] mask_q, mask_d;
  logic [`NUM_EVENTS-1:0] buffer_q, buffer_d;
  logic [`NUM_EVENTS-1:0] clr;
  logic                   wr;
  logic                   event_q;

  assign reg_sel = periph_pkg::eu_reg_e'(add_i[3:2]);
  assign gnt_o   = req_i;  // never stalls
  assign wr      = req_i && !wen_i;

  always_comb
  begin
    for (int i = 0; i < `NUM_EVENTS; i++)
    begin
      be_bits[i] = be_i[i/8];
    end
  end

  always_comb
  begin
    mask_d = mask_q;
    clr    = '0;
    if (wr && (reg_sel == periph_pkg::EU_MASK))
    begin
      mask_d = (mask_q & ~be_bits) | (wdata_i[`NUM_EVENTS-1:0] & be_bits);
    end
    if (wr && (reg_sel == periph_pkg::EU_CLEAR))
    begin
      clr = wdata_i[`NUM_EVENTS-1:0] & be_bits;
    end
    buffer_d = (buffer_q & ~clr) | evt_i;  // set wins over clear
  end

  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      mask_q    <= '0;
      buffer_q  <= '0;
      event_q   <= 1'b0;
      r_valid_o <= 1'b0;
      r_rdata_o <= '0;
    end
    else
    begin
      mask_q    <= mask_d;
      buffer_q  <= buffer_d;
      event_q   <= |(buffer_d & mask_d);
      r_valid_o <= req_i;
      if (req_i && wen_i)
      begin
        case (reg_sel)
          periph_pkg::EU_MASK:   r_rdata_o <= `DATA_WIDTH'(mask_q);
          periph_pkg::EU_BUFFER: r_rdata_o <= `DATA_WIDTH'(buffer_q);
          periph_pkg::EU_STATUS: r_rdata_o <= `DATA_WIDTH'(buffer_q & mask_q);
          default:               r_rdata_o <= '0;
        endcase
      end
    end
  end

  assign event_o = event_q;

endmodule

// File: source/periph_demux.sv
`timescale 1ns/10ps
`include "periph_macros.svh"

module periph_demux
(
  input  logic                   clk,
  input  logic                   rst_ni,

  input  logic                   data_req_i,
  input  logic [`ADDR_WIDTH-1:0] data_add_i,
  input  logic                   data_wen_i,
  input  logic [`DATA_WIDTH-1:0] data_wdata_i,
  input  logic [`BE_WIDTH-1:0]   data_be_i,
  output logic                   data_gnt_o,
  output logic                   data_r_valid_o,
  output logic [`DATA_WIDTH-1:0] data_r_rdata_o,
  output logic                   data_r_opc_o,

  output logic                   eu_req_o,
  input  logic                   eu_gnt_i,
  input  logic                   eu_r_valid_i,
  input  logic [`DATA_WIDTH-1:0] eu_r_rdata_i,

  output logic                   dma_req_o,
  input  logic                   dma_gnt_i,
  input  logic                   dma_r_valid_i,
  input  logic [`DATA_WIDTH-1:0] dma_r_rdata_i,

  output logic [`ADDR_WIDTH-1:0] add_o,
  output logic                   wen_o,
  output logic [`DATA_WIDTH-1:0] wdata_o,
  output logic [`BE_WIDTH-1:0]   be_o
);

  periph_pkg::periph_dest_e dest;
  periph_pkg::periph_dest_e dest_q;  // target of last granted request
  logic                     err_valid_q;

  // shared request payload
  assign add_o   = data_add_i;
  assign wen_o   = data_wen_i;
  assign wdata_o = data_wdata_i;
  assign be_o    = data_be_i;

  always_comb
  begin
    dest = periph_pkg::DEST_ERR;
    if (data_add_i[19:14] == `PERIPH_REGION)
    begin
      case (data_add_i[13:10])
        `EU_SEL:  dest = periph_pkg::DEST_EU;
        `DMA_SEL: dest = periph_pkg::DEST_DMA;
        default:  dest = periph_pkg::DEST_ERR;
      endcase
    end
  end

  always_comb
  begin
    eu_req_o   = 1'b0;
    dma_req_o  = 1'b0;
    data_gnt_o = 1'b0;
    case (dest)
      periph_pkg::DEST_EU:
      begin
        eu_req_o   = data_req_i;
        data_gnt_o = eu_gnt_i;
      end
      periph_pkg::DEST_DMA:
      begin
        dma_req_o  = data_req_i;
        data_gnt_o = dma_gnt_i;
      end
      default:
      begin
        data_gnt_o = data_req_i;  // bad address never stalls
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      dest_q      <= periph_pkg::DEST_EU;
      err_valid_q <= 1'b0;
    end
    else
    begin
      if (data_req_i && data_gnt_o)
      begin
        dest_q <= dest;
      end
      err_valid_q <= data_req_i && data_gnt_o && (dest == periph_pkg::DEST_ERR);
    end
  end

  always_comb
  begin
    case (dest_q)
      periph_pkg::DEST_EU:
      begin
        data_r_valid_o = eu_r_valid_i;
        data_r_rdata_o = eu_r_rdata_i;
        data_r_opc_o   = 1'b0;
      end
      periph_pkg::DEST_DMA:
      begin
        data_r_valid_o = dma_r_valid_i;
        data_r_rdata_o = dma_r_rdata_i;
        data_r_opc_o   = 1'b0;
      end
      default:
      begin
        data_r_valid_o = err_valid_q;
        data_r_rdata_o = '0;
        data_r_opc_o   = err_valid_q;  // error response
      end
    endcase
  end

  // response follows the previous cycle's grant to the same target
  a_resp_after_gnt: assert property (@(posedge clk) disable iff (!rst_ni)
    data_r_valid_o |-> $past(data_req_i && data_gnt_o) && ($past(dest) == dest_q));

  a_one_target: assert property (@(posedge clk) disable iff (!rst_ni)
    !(eu_req_o && dma_req_o));

endmodule

// File: source/periph_pkg.sv
`include "periph_macros.svh"

package periph_pkg;

  typedef enum logic [1:0]
  {
    DEST_EU,
    DEST_DMA,
    DEST_ERR
  } periph_dest_e;

  typedef enum logic [$clog2(`EU_NUM_REGS)-1:0]
  {
    EU_MASK,
    EU_BUFFER,
    EU_CLEAR,  // write one to clear
    EU_STATUS  // buffer & mask
  } eu_reg_e;

  typedef enum logic [$clog2(`DMA_NUM_REGS)-1:0]
  {
    DMA_SRC,
    DMA_DST,
    DMA_LEN,
    DMA_CMD
  } dma_reg_e;

endpackage

// File: source/periph_macros.svh
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// core port widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define BE_WIDTH 4

// address bits 19:14 for a peripheral hit
`define PERIPH_REGION 6'd1

// address bits 13:10 per target
`define EU_SEL 4'd0
`define DMA_SEL 4'd1

// word indexed register counts per target
`define EU_NUM_REGS 4
`define DMA_NUM_REGS 4

`define NUM_EVENTS 8
`define DMA_LEN_WIDTH 16

`endif
